/* logic/issue_consts.svh */
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// Data path width
`define XLEN 32

// Sign-extended branch and jump offset
`define PC_OFFSET_W 21

// ALU, branch unit, load/store unit
`define NUM_UNITS 3

// Link registers for return-address prediction hints
`define LINK_REG_A 5'd1
`define LINK_REG_B 5'd5

// Register address width and id width
`define REG_ADDR_W 5
`define ID_W 4

// Load/store immediate width
`define LS_OFFSET_W 12

`endif

/* logic/issue_pkg.sv */
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // Major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LUI_T       = 5'b01101,
        AUIPC_T     = 5'b00101,
        JAL_T       = 5'b11011,
        JALR_T      = 5'b11001,
        BRANCH_T    = 5'b11000,
        LOAD_T      = 5'b00000,
        STORE_T     = 5'b01000,
        ARITH_IMM_T = 5'b00100,
        ARITH_T     = 5'b01100,
        SYSTEM_T    = 5'b11100
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'd0,
        ALU_SLT      = 2'd1,
        ALU_SHIFT    = 2'd2,
        ALU_ADD_SUB  = 2'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_ADD = 2'd0,
        ALU_LOGIC_XOR = 2'd1,
        ALU_LOGIC_OR  = 2'd2,
        ALU_LOGIC_AND = 2'd3
    } alu_logic_op_t;

    typedef struct packed {
        logic alu;
        logic br;
        logic ls;
    } unit_vec_t;

    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        logic [31:0]          instr;
        logic [`ID_W-1:0]     id;
    } decode_pkt_t;

    typedef struct packed {
        unit_vec_t                 units;
        logic                      uses_rs1;
        logic                      uses_rs2;
        logic [`REG_ADDR_W-1:0]    rs1;
        logic [`REG_ADDR_W-1:0]    rs2;
        logic [`REG_ADDR_W-1:0]    rd;
        logic [2:0]                fn3;
        // ALU pre-decode
        alu_op_t                   alu_op;
        alu_logic_op_t             logic_op;
        logic                      subtract;
        logic                      imm_type;
        logic [`XLEN-1:0]          constant_adder;
        // Branch pre-decode
        logic [`PC_OFFSET_W-1:0]   pc_offset;
        logic                      jal;
        logic                      jalr;
        logic                      is_call;
        logic                      is_return;
        logic                      br_signed;
        // Load/store pre-decode
        logic [`LS_OFFSET_W-1:0]   ls_offset;
        logic                      is_load;
        logic                      is_store;
    } decoded_t;

    typedef struct packed {
        decoded_t              dec;
        logic [`XLEN-1:0]      pc;
        logic [31:0]           instr;
        logic [`ID_W-1:0]      id;
        logic                  stage_valid;
    } issue_reg_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
    } rs_data_t;

    typedef struct packed {
        logic [`XLEN:0]    in1;
        logic [`XLEN:0]    in2;
        logic              subtract;
        alu_logic_op_t     logic_op;
        alu_op_t           alu_op;
        logic [`XLEN-1:0]  constant_adder;
        logic [4:0]        shift_amount;
        logic              lshift;
        logic              arith;
        logic [`XLEN-1:0]  shifter_in;
    } alu_inputs_t;

    typedef struct packed {
        logic [`XLEN:0]            rs1;
        logic [`XLEN:0]            rs2;
        logic [2:0]                fn3;
        logic [`PC_OFFSET_W-1:0]   pc_offset;
        logic                      jal;
        logic                      jalr;
        logic                      jal_jalr;
        logic                      is_call;
        logic                      is_return;
        logic [`XLEN-1:0]          issue_pc;
        logic [`XLEN-1:0]          pc_p4;
    } branch_inputs_t;

    typedef struct packed {
        logic [`LS_OFFSET_W-1:0]   offset;
        logic                      load;
        logic                      store;
        logic [2:0]                fn3;
        logic [`XLEN-1:0]          rs1;
        logic [`XLEN-1:0]          rs2;
    } ls_inputs_t;

endpackage

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module instr_decoder (
    input  wire logic [31:0]        instr_i,
    input  wire logic [`XLEN-1:0]   pc_i,
    output issue_pkg::decoded_t     dec_o
);

    issue_pkg::opcode_t opcode;
    logic [2:0] fn3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rd;

    issue_pkg::alu_op_t alu_op;
    issue_pkg::alu_logic_op_t logic_op;
    logic is_lui;
    logic is_upper;

    logic rs1_link;
    logic rd_link;
    logic [`PC_OFFSET_W-1:0] pc_offset;

    // Instruction fields
    assign opcode = issue_pkg::opcode_t'(instr_i[6:2]);
    assign fn3 = instr_i[14:12];
    assign rs1 = instr_i[19:15];
    assign rd = instr_i[11:7];

    assign dec_o.rs1 = rs1;
    assign dec_o.rs2 = instr_i[24:20];
    assign dec_o.rd = rd;
    assign dec_o.fn3 = fn3;

    ////////////////////
    // Unit selection and operand use
    assign dec_o.units.br = opcode inside {issue_pkg::BRANCH_T, issue_pkg::JAL_T,
        issue_pkg::JALR_T};
    assign dec_o.units.alu = opcode inside {issue_pkg::ARITH_T, issue_pkg::ARITH_IMM_T,
        issue_pkg::LUI_T, issue_pkg::AUIPC_T, issue_pkg::JAL_T, issue_pkg::JALR_T};
    assign dec_o.units.ls = opcode inside {issue_pkg::LOAD_T, issue_pkg::STORE_T};

    assign dec_o.uses_rs1 = opcode inside {issue_pkg::JALR_T, issue_pkg::BRANCH_T,
        issue_pkg::LOAD_T, issue_pkg::STORE_T, issue_pkg::ARITH_IMM_T, issue_pkg::ARITH_T};
    // Store data comes straight from the register file
    assign dec_o.uses_rs2 = opcode inside {issue_pkg::BRANCH_T, issue_pkg::STORE_T,
        issue_pkg::ARITH_T};

    ////////////////////
    // ALU pre-decode
    always_comb begin
        case (opcode) inside
            issue_pkg::LUI_T, issue_pkg::AUIPC_T, issue_pkg::JAL_T, issue_pkg::JALR_T:
                alu_op = issue_pkg::ALU_CONSTANT;
            default: begin
                case (fn3) inside
                    3'b010, 3'b011: alu_op = issue_pkg::ALU_SLT;
                    3'b001, 3'b101: alu_op = issue_pkg::ALU_SHIFT;
                    default: alu_op = issue_pkg::ALU_ADD_SUB;
                endcase
            end
        endcase
    end

    always_comb begin
        case (fn3)
            3'b100: logic_op = issue_pkg::ALU_LOGIC_XOR;
            3'b110: logic_op = issue_pkg::ALU_LOGIC_OR;
            3'b111: logic_op = issue_pkg::ALU_LOGIC_AND;
            default: logic_op = issue_pkg::ALU_LOGIC_ADD;
        endcase
    end

    assign dec_o.alu_op = alu_op;
    assign dec_o.logic_op = logic_op;
    // SLT/SLTU compare through the subtractor, SUB only in register form
    assign dec_o.subtract = (fn3 inside {3'b010, 3'b011})
        || ((opcode == issue_pkg::ARITH_T) && (fn3 == 3'b000) && instr_i[30]);
    assign dec_o.imm_type = (opcode == issue_pkg::ARITH_IMM_T);

    // Constant adder: upper immediate, pc + upper immediate, or pc + 4
    assign is_lui = (opcode == issue_pkg::LUI_T);
    assign is_upper = is_lui || (opcode == issue_pkg::AUIPC_T);
    assign dec_o.constant_adder = (is_lui ? '0 : pc_i)
        + (is_upper ? {instr_i[31:12], 12'b0} : `XLEN'(4));

    ////////////////////
    // Branch pre-decode
    always_comb begin
        case (opcode)
            issue_pkg::JAL_T:
                pc_offset = `PC_OFFSET_W'(signed'({instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0}));
            issue_pkg::JALR_T:
                pc_offset = `PC_OFFSET_W'(signed'(instr_i[31:20]));
            default:
                pc_offset = `PC_OFFSET_W'(signed'({instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0}));
        endcase
    end

    assign dec_o.pc_offset = pc_offset;
    assign dec_o.jal = (opcode == issue_pkg::JAL_T);
    assign dec_o.jalr = (opcode == issue_pkg::JALR_T);

    // Call/return hints from the link register rule
    assign rs1_link = (rs1 == `LINK_REG_A) || (rs1 == `LINK_REG_B);
    assign rd_link = (rd == `LINK_REG_A) || (rd == `LINK_REG_B);
    assign dec_o.is_call = (dec_o.jal || dec_o.jalr) && rd_link;
    assign dec_o.is_return = dec_o.jalr && rs1_link && (!rd_link || (rs1 != rd));

    // BLTU and BGEU compare unsigned
    assign dec_o.br_signed = !(fn3 inside {3'b110, 3'b111});

    ////////////////////
    // Load/store pre-decode
    assign dec_o.is_load = (opcode == issue_pkg::LOAD_T);
    assign dec_o.is_store = (opcode == issue_pkg::STORE_T);
    assign dec_o.ls_offset = dec_o.is_store ? {instr_i[31:25], instr_i[11:7]}
                                            : instr_i[31:20];

endmodule

`default_nettype wire

/* logic/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_stage (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // Decode side
    input  wire issue_pkg::decode_pkt_t    dec_i,
    input  wire issue_pkg::decoded_t       decoded_i,
    output logic                           dec_ready_o,

    // Control
    input  wire logic                      flush_i,
    input  wire logic                      issue_hold_i,

    // Register file
    input  wire logic [1:0]                rs_inuse_i,
    output logic [2*`REG_ADDR_W-1:0]       rf_rs_addr_o,

    // Units
    input  wire issue_pkg::unit_vec_t      unit_ready_i,
    output issue_pkg::issue_reg_t          issue_o,
    output issue_pkg::unit_vec_t           unit_req_o,
    output logic [`ID_W-1:0]               issue_id_o,
    output logic                           issued_o
);

    issue_pkg::issue_reg_t issue_q;

    logic rs1_conflict;
    logic rs2_conflict;
    logic operands_ready;
    logic [`NUM_UNITS-1:0] units_needed;
    logic [`NUM_UNITS-1:0] units_ready;
    logic units_free;
    logic issue_valid;

    ////////////////////
    // Issue register

    // Load when empty or when the current instruction leaves this cycle
    assign dec_ready_o = (~issue_q.stage_valid | issued_o) & ~flush_i;

    always_ff @(posedge clk) begin
        if (dec_ready_o) begin
            issue_q.dec <= decoded_i;
            issue_q.pc <= dec_i.pc;
            issue_q.instr <= dec_i.instr;
            issue_q.id <= dec_i.id;
        end
        if (rst || flush_i) begin
            issue_q.stage_valid <= 1'b0;
        end else if (dec_ready_o) begin
            issue_q.stage_valid <= dec_i.valid;
        end
    end

    ////////////////////
    // Issue decision
    assign rs1_conflict = rs_inuse_i[0] & issue_q.dec.uses_rs1;
    assign rs2_conflict = rs_inuse_i[1] & issue_q.dec.uses_rs2;
    assign operands_ready = ~rs1_conflict & ~rs2_conflict;

    // Every unit the instruction needs must be ready
    assign units_needed = issue_q.dec.units;
    assign units_ready = unit_ready_i;
    assign units_free = ((units_needed & ~units_ready) == '0);

    assign issue_valid = issue_q.stage_valid & operands_ready & ~issue_hold_i & ~flush_i;
    assign issued_o = issue_valid & units_free;

    // Empty unit vector gives an issue with no request
    assign unit_req_o = issued_o ? issue_q.dec.units : '0;
    assign issue_id_o = issue_q.id;

    // Register file read addresses, rs2 in the upper half
    assign rf_rs_addr_o = {issue_q.dec.rs2, issue_q.dec.rs1};

    assign issue_o = issue_q;

endmodule

`default_nettype wire

/* logic/unit_operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module unit_operand_mux (
    input  wire issue_pkg::issue_reg_t    issue_i,
    input  wire issue_pkg::rs_data_t      rs_data_i,
    output issue_pkg::alu_inputs_t        alu_o,
    output issue_pkg::branch_inputs_t     branch_o,
    output issue_pkg::ls_inputs_t         ls_o
);

    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] alu_rs2;
    logic alu_signed;
    logic br_signed;

    assign rs1 = rs_data_i.rs1;
    assign rs2 = rs_data_i.rs2;

    ////////////////////
    // ALU inputs

    // fn3[0] set only for SLTU/SLTIU among compares
    assign alu_signed = ~issue_i.dec.fn3[0];
    assign alu_rs2 = issue_i.dec.imm_type ? `XLEN'(signed'(issue_i.instr[31:20])) : rs2;

    assign alu_o.in1 = {rs1[`XLEN-1] & alu_signed, rs1};
    assign alu_o.in2 = {alu_rs2[`XLEN-1] & alu_signed, alu_rs2};
    assign alu_o.subtract = issue_i.dec.subtract;
    assign alu_o.logic_op = issue_i.dec.logic_op;
    assign alu_o.alu_op = issue_i.dec.alu_op;
    assign alu_o.constant_adder = issue_i.dec.constant_adder;

    // Shifter, immediate shift amount sits in the rs2 field
    assign alu_o.shift_amount = issue_i.dec.imm_type ? issue_i.dec.rs2 : rs2[4:0];
    assign alu_o.lshift = ~issue_i.dec.fn3[2];
    assign alu_o.arith = rs1[`XLEN-1] & issue_i.instr[30];
    assign alu_o.shifter_in = rs1;

    ////////////////////
    // Branch inputs
    assign br_signed = issue_i.dec.br_signed;

    assign branch_o.rs1 = {rs1[`XLEN-1] & br_signed, rs1};
    assign branch_o.rs2 = {rs2[`XLEN-1] & br_signed, rs2};
    assign branch_o.fn3 = issue_i.dec.fn3;
    assign branch_o.pc_offset = issue_i.dec.pc_offset;
    assign branch_o.jal = issue_i.dec.jal;
    assign branch_o.jalr = issue_i.dec.jalr;
    assign branch_o.jal_jalr = issue_i.dec.jal | issue_i.dec.jalr;
    assign branch_o.is_call = issue_i.dec.is_call;
    assign branch_o.is_return = issue_i.dec.is_return;
    assign branch_o.issue_pc = issue_i.pc;
    // Constant adder holds pc + 4 for branches and jumps
    assign branch_o.pc_p4 = issue_i.dec.constant_adder;

    ////////////////////
    // Load/store inputs
    assign ls_o.offset = issue_i.dec.ls_offset;
    assign ls_o.load = issue_i.dec.is_load;
    assign ls_o.store = issue_i.dec.is_store;
    assign ls_o.fn3 = issue_i.dec.fn3;
    assign ls_o.rs1 = rs1;
    assign ls_o.rs2 = rs2;

endmodule

`default_nettype wire

/* logic/decode_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module decode_issue_top (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire issue_pkg::decode_pkt_t      dec_i,
    output logic                             dec_ready_o,

    input  wire logic                        flush_i,
    input  wire logic                        issue_hold_i,

    input  wire logic [1:0]                  rs_inuse_i,
    input  wire issue_pkg::rs_data_t         rs_data_i,
    output logic [2*`REG_ADDR_W-1:0]         rf_rs_addr_o,

    input  wire issue_pkg::unit_vec_t        unit_ready_i,
    output issue_pkg::unit_vec_t             unit_req_o,
    output logic [`ID_W-1:0]                 issue_id_o,
    output logic                             issued_o,

    output issue_pkg::alu_inputs_t           alu_o,
    output issue_pkg::branch_inputs_t        branch_o,
    output issue_pkg::ls_inputs_t            ls_o
);

    issue_pkg::decoded_t decoded;
    issue_pkg::issue_reg_t issue_q;

    // Decode straight off the incoming packet
    instr_decoder decoder_i (
        .instr_i (dec_i.instr),
        .pc_i    (dec_i.pc),
        .dec_o   (decoded)
    );

    issue_stage stage_i (
        .clk          (clk),
        .rst          (rst),
        .dec_i        (dec_i),
        .decoded_i    (decoded),
        .dec_ready_o  (dec_ready_o),
        .flush_i      (flush_i),
        .issue_hold_i (issue_hold_i),
        .rs_inuse_i   (rs_inuse_i),
        .rf_rs_addr_o (rf_rs_addr_o),
        .unit_ready_i (unit_ready_i),
        .issue_o      (issue_q),
        .unit_req_o   (unit_req_o),
        .issue_id_o   (issue_id_o),
        .issued_o     (issued_o)
    );

    unit_operand_mux operand_mux_i (
        .issue_i   (issue_q),
        .rs_data_i (rs_data_i),
        .alu_o     (alu_o),
        .branch_o  (branch_o),
        .ls_o      (ls_o)
    );

endmodule

`default_nettype wire

/* test/tb_instr_table.svh */
`ifndef TB_INSTR_TABLE_SVH
`define TB_INSTR_TABLE_SVH

// One row per instruction with the fields expected from the decode rules
typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [3:0]  id;
    logic [2:0]  units;      // alu, br, ls
    logic [1:0]  alu_op;
    logic [1:0]  logic_op;
    logic        sub;
    logic [31:0] cadd;
    logic [20:0] pc_off;
    logic [1:0]  hint;       // call, return
    logic [11:0] ls_off;
    logic        flush;
} row_t;

localparam int NUM_ROWS = 22;

localparam row_t ROWS [NUM_ROWS] = '{
    '{'h002081B3, 'h1000, 'h0, 'b100, 3, 0, 0, 'h1004, 0, 0, 0, 0},
    '{'h40628233, 'h1004, 'h1, 'b100, 3, 0, 1, 'h1008, 0, 0, 0, 0},
    '{'h009423B3, 'h1008, 'h2, 'b100, 1, 0, 1, 'h100C, 0, 0, 0, 0},
    '{'h00C5B533, 'h100C, 'h3, 'b100, 1, 0, 1, 'h1010, 0, 0, 0, 0},
    '{'hFFF74693, 'h2000, 'h4, 'b100, 3, 1, 0, 'h2004, 0, 0, 0, 0},
    '{'h011867B3, 'h2004, 'h5, 'b100, 3, 2, 0, 'h2008, 0, 0, 0, 0},
    '{'h7F09F913, 'h2008, 'h6, 'b100, 3, 3, 0, 'h200C, 0, 0, 0, 0},
    '{'h407ADA13, 'h200C, 'h7, 'b100, 2, 0, 0, 'h2010, 0, 0, 0, 0},
    '{'h018B9B33, 'h2010, 'h8, 'b100, 2, 0, 0, 'h2014, 0, 0, 0, 0},
    '{'hABCDE0B7, 'h3000, 'h9, 'b100, 0, 2, 0, 'hABCDE000, 0, 0, 0, 0},
    '{'h00010117, 'h3004, 'hA, 'b100, 0, 0, 0, 'h13004, 0, 0, 0, 0},
    '{'h001000EF, 'h4000, 'hB, 'b110, 0, 0, 0, 'h4004, 'h000800, 'b10, 0, 0},
    '{'hFFDFF06F, 'h4100, 'hC, 'b110, 0, 3, 0, 'h4104, 'h1FFFFC, 'b00, 0, 0},
    '{'h00008067, 'h4200, 'hD, 'b110, 0, 0, 0, 'h4204, 'h000000, 'b01, 0, 0},
    '{'hFF0302E7, 'h4300, 'hE, 'b110, 0, 0, 0, 'h4304, 'h1FFFF0, 'b10, 0, 0},
    '{'h00208863, 'h5000, 'hF, 'b010, 0, 0, 0, 'h5004, 'h000010, 'b00, 0, 0},
    '{'hFE41ECE3, 'h5100, 'h0, 'b010, 0, 0, 0, 'h5104, 'h1FFFF8, 'b00, 0, 0},
    '{'hFFC52483, 'h6000, 'h1, 'b001, 0, 0, 0, 'h6004, 0, 0, 'hFFC, 0},
    '{'h12B601A3, 'h6004, 'h2, 'b001, 0, 0, 0, 'h6008, 0, 0, 'h123, 0},
    '{'h00000073, 'h7000, 'h3, 'b000, 0, 0, 0, 'h7004, 0, 0, 0, 0},
    '{'h002081B3, 'h8000, 'h4, 'b100, 3, 0, 0, 'h8004, 0, 0, 0, 1},
    '{'h00510093, 'h8004, 'h5, 'b100, 3, 0, 0, 'h8008, 0, 0, 0, 0}
};

`endif

/* test/tb_decode_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_issue;

    `include "tb_instr_table.svh"

    localparam int CLK_PERIOD = 4;

    logic clk;
    logic rst;
    issue_pkg::decode_pkt_t dec_i;
    logic dec_ready_o;
    logic flush_i;
    logic issue_hold_i;
    logic [1:0] rs_inuse_i;
    issue_pkg::rs_data_t rs_data_i;
    logic [9:0] rf_rs_addr_o;
    issue_pkg::unit_vec_t unit_ready_i;
    issue_pkg::unit_vec_t unit_req_o;
    logic [3:0] issue_id_o;
    logic issued_o;
    issue_pkg::alu_inputs_t alu_o;
    issue_pkg::branch_inputs_t branch_o;
    issue_pkg::ls_inputs_t ls_o;

    decode_issue_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .dec_i        (dec_i),
        .dec_ready_o  (dec_ready_o),
        .flush_i      (flush_i),
        .issue_hold_i (issue_hold_i),
        .rs_inuse_i   (rs_inuse_i),
        .rs_data_i    (rs_data_i),
        .rf_rs_addr_o (rf_rs_addr_o),
        .unit_ready_i (unit_ready_i),
        .unit_req_o   (unit_req_o),
        .issue_id_o   (issue_id_o),
        .issued_o     (issued_o),
        .alu_o        (alu_o),
        .branch_o     (branch_o),
        .ls_o         (ls_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Register file model with x0 reading zero
    function automatic logic [31:0] reg_value(input logic [4:0] r);
        if (r == 5'd0) begin
            return 32'd0;
        end
        return {r, 3'b101, r, 3'b010, r, 3'b110, r, 3'b011};
    endfunction

    always_comb begin
        rs_data_i.rs1 = reg_value(rf_rs_addr_o[4:0]);
        rs_data_i.rs2 = reg_value(rf_rs_addr_o[9:5]);
    end

    ////////////////////
    // Compare tasks
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic check_id(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: issue_id_o got %h expected %h",
                $time, got, exp));
        end
    endtask

    task automatic check_units(input issue_pkg::unit_vec_t got,
                               input issue_pkg::unit_vec_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: unit_req_o got %b expected %b",
                $time, got, exp));
        end
    endtask

    task automatic check_alu(input issue_pkg::alu_inputs_t got,
                             input issue_pkg::alu_inputs_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: alu_o got %h expected %h",
                $time, got, exp));
        end
    endtask

    task automatic check_branch(input issue_pkg::branch_inputs_t got,
                                input issue_pkg::branch_inputs_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: branch_o got %h expected %h",
                $time, got, exp));
        end
    endtask

    task automatic check_ls(input issue_pkg::ls_inputs_t got,
                            input issue_pkg::ls_inputs_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: ls_o got %h expected %h",
                $time, got, exp));
        end
    endtask

    ////////////////////
    // Expected bundles from the row and the register model
    task automatic check_bundles(input row_t r);
        issue_pkg::alu_inputs_t ea;
        issue_pkg::branch_inputs_t eb;
        issue_pkg::ls_inputs_t el;
        issue_pkg::opcode_t opc;
        logic [2:0] fn3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] op2;
        logic is_imm;
        logic sgn;
        opc = issue_pkg::opcode_t'(r.instr[6:2]);
        fn3 = r.instr[14:12];
        a = reg_value(r.instr[19:15]);
        b = reg_value(r.instr[24:20]);
        is_imm = (opc == issue_pkg::ARITH_IMM_T);
        op2 = is_imm ? {{20{r.instr[31]}}, r.instr[31:20]} : b;
        // Odd fn3 zero extends (SLTU and friends)
        ea.in1 = {a[31] & ~fn3[0], a};
        ea.in2 = {op2[31] & ~fn3[0], op2};
        ea.subtract = r.sub;
        ea.logic_op = issue_pkg::alu_logic_op_t'(r.logic_op);
        ea.alu_op = issue_pkg::alu_op_t'(r.alu_op);
        ea.constant_adder = r.cadd;
        ea.shift_amount = is_imm ? r.instr[24:20] : b[4:0];
        ea.lshift = ~fn3[2];
        ea.arith = r.instr[30] & a[31];
        ea.shifter_in = a;
        // BLTU and BGEU compare unsigned
        sgn = !(fn3 == 3'b110 || fn3 == 3'b111);
        eb.rs1 = {a[31] & sgn, a};
        eb.rs2 = {b[31] & sgn, b};
        eb.fn3 = fn3;
        eb.pc_offset = r.pc_off;
        eb.jal = (opc == issue_pkg::JAL_T);
        eb.jalr = (opc == issue_pkg::JALR_T);
        eb.jal_jalr = eb.jal | eb.jalr;
        eb.is_call = r.hint[1];
        eb.is_return = r.hint[0];
        eb.issue_pc = r.pc;
        eb.pc_p4 = r.pc + 32'd4;
        el.offset = r.ls_off;
        el.load = (opc == issue_pkg::LOAD_T);
        el.store = (opc == issue_pkg::STORE_T);
        el.fn3 = fn3;
        el.rs1 = a;
        el.rs2 = b;
        if (r.units[2]) check_alu(alu_o, ea);
        if (r.units[1]) check_branch(branch_o, eb);
        if (r.units[0]) check_ls(ls_o, el);
    endtask

    ////////////////////
    // One table row
    task automatic run_row(input row_t r);
        issue_pkg::opcode_t opc;
        logic use1;
        logic use2;
        logic [2:0] ready_bits;
        logic exp_issue;
        logic done;
        int waited;
        opc = issue_pkg::opcode_t'(r.instr[6:2]);
        use1 = opc inside {issue_pkg::JALR_T, issue_pkg::BRANCH_T, issue_pkg::LOAD_T,
            issue_pkg::STORE_T, issue_pkg::ARITH_IMM_T, issue_pkg::ARITH_T};
        use2 = opc inside {issue_pkg::BRANCH_T, issue_pkg::STORE_T, issue_pkg::ARITH_T};
        @(negedge clk);
        dec_i.valid = 1'b1;
        dec_i.pc = r.pc;
        dec_i.instr = r.instr;
        dec_i.id = r.id;
        unit_ready_i = '0;
        rs_inuse_i = 2'b00;
        issue_hold_i = 1'b0;
        #1;
        check_flag("dec_ready_o", dec_ready_o, 1'b1);
        @(negedge clk);
        dec_i.valid = 1'b0;
        if (r.flush) begin
            flush_i = 1'b1;
            unit_ready_i = '1;
            #1;
            check_flag("issued_o", issued_o, 1'b0);
            check_units(unit_req_o, '0);
            @(negedge clk);
            flush_i = 1'b0;
            #1;
            check_flag("issued_o", issued_o, 1'b0);
            check_flag("dec_ready_o", dec_ready_o, 1'b1);
            return;
        end
        done = 1'b0;
        waited = 0;
        while (!done) begin
            // Random stalls for a few cycles, then a clear path
            if (waited < 8) begin
                ready_bits = 3'($urandom | $urandom);
                rs_inuse_i = 2'($urandom & $urandom);
                issue_hold_i = ($urandom % 8) == 0;
            end else begin
                ready_bits = 3'b111;
                rs_inuse_i = 2'b00;
                issue_hold_i = 1'b0;
            end
            unit_ready_i = ready_bits;
            #1;
            exp_issue = !issue_hold_i && !(use1 && rs_inuse_i[0])
                && !(use2 && rs_inuse_i[1]) && ((r.units & ~ready_bits) == 3'b000);
            check_flag("issued_o", issued_o, exp_issue);
            check_flag("dec_ready_o", dec_ready_o, exp_issue);
            if (exp_issue) begin
                check_units(unit_req_o, r.units);
                check_id(issue_id_o, r.id);
                check_bundles(r);
                done = 1'b1;
            end else begin
                check_units(unit_req_o, '0);
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // Watchdog
    initial begin
        #((NUM_ROWS * 40 + 10) * CLK_PERIOD);
        stop_on_failure("Timeout: the test did not finish in the allowed time");
    end

    initial begin
        void'($urandom(32'heb7fb494));
        rst = 1'b1;
        dec_i = '0;
        flush_i = 1'b0;
        issue_hold_i = 1'b0;
        rs_inuse_i = 2'b00;
        unit_ready_i = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag("issued_o", issued_o, 1'b0);
        check_flag("dec_ready_o", dec_ready_o, 1'b1);
        check_units(unit_req_o, '0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROWS[i]);
        end
        @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
+incdir+test
logic/issue_pkg.sv
logic/instr_decoder.sv
logic/issue_stage.sv
logic/unit_operand_mux.sv
logic/decode_issue_top.sv
test/tb_decode_issue.sv

/* Bender.yml */
package:
  name: decode_issue

sources:
  - include_dirs:
      - logic
    files:
      - logic/issue_pkg.sv
      - logic/instr_decoder.sv
      - logic/issue_stage.sv
      - logic/unit_operand_mux.sv
      - logic/decode_issue_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/tb_decode_issue.sv
